//--- filelist.f
div_pkg.sv
div_iter_counter.sv
div_fsm.sv
div_lead_zero.sv
div_nonrestoring_datapath.sv
div32_nonrestoring_skip.sv
div32_nonrestoring_skip_wrapper.sv
tb_div32_nonrestoring_skip.sv

//--- Bender.yml
package:
  name: div32_nonrestoring_skip

sources:
  # design, in compile order
  - div_pkg.sv
  - div_iter_counter.sv
  - div_fsm.sv
  - div_lead_zero.sv
  - div_nonrestoring_datapath.sv
  - div32_nonrestoring_skip.sv
  - div32_nonrestoring_skip_wrapper.sv
  # testbench
  - target: simulation
    files:
      - tb_div32_nonrestoring_skip.sv

//--- tb_div32_nonrestoring_skip.sv
`timescale 1ns/1ps

module tb_div32_nonrestoring_skip;

    // ------------------------------------------------------------------------
    // run limits

    // upper bound on divisions issued, abort and stall included
    localparam int NUM_OPS        = 64;
    // worst case per division is 36 edges plus restart, 40 with slack
    localparam int TIMEOUT_CYCLES = NUM_OPS * 40 + 16 + 200;
    // give up on a single division after this many edges
    localparam int DONE_WAIT_MAX  = 80;

    logic        CLK;
    logic        nRST;
    logic        next_clear;
    logic        next_is_signed;
    logic        next_stall_if_done;
    logic [31:0] next_A32_in;
    logic [31:0] next_B32_in;
    logic        last_done;
    logic [31:0] last_quotient_out;
    logic [31:0] last_remainder_out;

    int          error_count = 0;
    int          check_count = 0;
    int          cycle_count = 0;
    logic [31:0] rng_state   = 32'd52;

    div32_nonrestoring_skip_wrapper i_dut (
        .CLK                (CLK),
        .nRST               (nRST),
        .next_clear         (next_clear),
        .next_is_signed     (next_is_signed),
        .next_stall_if_done (next_stall_if_done),
        .last_done          (last_done),
        .next_A32_in        (next_A32_in),
        .next_B32_in        (next_B32_in),
        .last_quotient_out  (last_quotient_out),
        .last_remainder_out (last_remainder_out)
    );

    // 10 ns clock
    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    // hard stop in case a wait never ends
    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ------------------------------------------------------------------------
    // stimulus and reference

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // random value with a random number of leading zeros
    function automatic logic [31:0] rand_operand();
        logic [31:0] r;
        logic [31:0] s;
        r = lcg_next();
        s = lcg_next();
        return r >> s[31:27];
    endfunction

    // RISC-V division rules, {quotient, remainder}
    function automatic logic [63:0] ref_divide(input logic [31:0] a, input logic [31:0] b,
                                               input logic sgn);
        int sa;
        int sb;
        sa = a;
        sb = b;
        if (b == 32'd0) return {32'hFFFF_FFFF, a};
        if (!sgn) return {a / b, a % b};
        // overflow case
        if (a == 32'h8000_0000 && b == 32'hFFFF_FFFF) return {a, 32'd0};
        return {32'(sa / sb), 32'(sa % sb)};
    endfunction

    // quotient bits left after skipping the dividend's leading zeros
    function automatic int expected_steps(input logic [31:0] a, input logic sgn);
        logic [31:0] mag;
        int          lz;
        mag = (sgn && a[31]) ? -a : a;
        lz  = 0;
        while (lz < 32 && !mag[31 - lz]) lz++;
        if (mag == 32'd0) return 1;
        return 32 - lz;
    endfunction

    // ------------------------------------------------------------------------
    // checks

    task automatic check_word(input string name, input string field,
                              input logic [31:0] expected, input logic [31:0] actual);
        check_count++;
        assert (actual === expected) else begin
            error_count++;
            $display("error %s %s: expected %h, actual %h", name, field, expected, actual);
        end
    endtask

    task automatic check_latency(input string name, input int expected, input int actual);
        check_count++;
        assert (actual == expected) else begin
            error_count++;
            $display("error %s latency: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    // ------------------------------------------------------------------------
    // division sequencing

    task automatic start_div(input logic [31:0] a, input logic [31:0] b, input logic sgn,
                             input logic stall);
        @(posedge CLK);
        next_A32_in        <= a;
        next_B32_in        <= b;
        next_is_signed     <= sgn;
        next_stall_if_done <= stall;
        next_clear         <= 1'b1;
        // input flops take the strobe on this edge
        @(posedge CLK);
        next_clear         <= 1'b0;
    endtask

    // edges from the clear sample to last_done, -1 if it never came
    task automatic wait_done(output int latency);
        int edges;
        edges   = 0;
        latency = -1;
        while (latency < 0 && edges < DONE_WAIT_MAX) begin
            @(posedge CLK);
            edges++;
            // outputs settled half a period after the edge
            @(negedge CLK);
            if (last_done) latency = edges;
        end
    endtask

    task automatic run_div(input string name, input logic [31:0] a, input logic [31:0] b,
                           input logic sgn, input logic stall);
        logic [63:0] expected;
        int          latency;
        expected = ref_divide(a, b, sgn);
        start_div(a, b, sgn, stall);
        wait_done(latency);
        if (latency < 0) begin
            error_count++;
            $display("%s: last_done never rose after the clear pulse", name);
        end else begin
            check_word(name, "quotient", expected[63:32], last_quotient_out);
            check_word(name, "remainder", expected[31:0], last_remainder_out);
            check_latency(name, expected_steps(a, sgn) + 4, latency);
        end
    endtask

    // ------------------------------------------------------------------------
    // main sequence

    initial begin
        logic [31:0] op_a;
        logic [31:0] op_b;
        logic [31:0] coin;
        logic [63:0] held;
        int          wait_edges;
        logic        fell;

        nRST               = 1'b0;
        next_clear         = 1'b0;
        next_is_signed     = 1'b0;
        next_stall_if_done = 1'b0;
        next_A32_in        = '0;
        next_B32_in        = '0;
        repeat (16) @(posedge CLK);
        nRST <= 1'b1;
        repeat (2) @(posedge CLK);

        // unsigned random
        repeat (16) begin
            op_a = rand_operand();
            op_b = rand_operand();
            run_div("unsigned_rand", op_a, op_b, 1'b0, 1'b0);
        end

        // signed random, mixed signs
        repeat (16) begin
            op_a = rand_operand();
            op_b = rand_operand();
            coin = lcg_next();
            if (coin[31]) op_a = -op_a;
            if (coin[30]) op_b = -op_b;
            run_div("signed_rand", op_a, op_b, 1'b1, 1'b0);
        end
        run_div("signed_overflow", 32'h8000_0000, 32'hFFFF_FFFF, 1'b1, 1'b0);
        run_div("signed_neg_pos", -32'sd7, 32'd2, 1'b1, 1'b0);
        run_div("signed_pos_neg", 32'd7, -32'sd2, 1'b1, 1'b0);
        run_div("signed_neg_neg", -32'sd7, -32'sd2, 1'b1, 1'b0);
        run_div("signed_min_one", 32'h8000_0000, 32'd1, 1'b1, 1'b0);

        // divide by zero
        run_div("div0_unsigned", 32'd123, 32'd0, 1'b0, 1'b0);
        run_div("div0_unsigned_ones", 32'hFFFF_FFFF, 32'd0, 1'b0, 1'b0);
        run_div("div0_signed_neg", -32'sd5, 32'd0, 1'b1, 1'b0);
        run_div("div0_signed_min", 32'h8000_0000, 32'd0, 1'b1, 1'b0);
        run_div("div0_zero", 32'd0, 32'd0, 1'b1, 1'b0);

        // latency across the skip range
        run_div("lat_zero", 32'd0, 32'd9, 1'b0, 1'b0);
        run_div("lat_one", 32'd1, 32'd3, 1'b0, 1'b0);
        run_div("lat_ones_unsigned", 32'hFFFF_FFFF, 32'd7, 1'b0, 1'b0);
        run_div("lat_ones_signed", 32'hFFFF_FFFF, 32'd7, 1'b1, 1'b0);
        run_div("lat_mid", 32'h0001_0000, 32'd5, 1'b0, 1'b0);
        run_div("lat_min_signed", 32'h8000_0000, 32'd3, 1'b1, 1'b0);

        // stall holds done and results
        held = ref_divide(32'd1000, 32'd7, 1'b0);
        run_div("stall", 32'd1000, 32'd7, 1'b0, 1'b1);
        repeat (8) begin
            @(negedge CLK);
            check_word("stall", "last_done", 32'd1, {31'd0, last_done});
            check_word("stall", "quotient", held[63:32], last_quotient_out);
            check_word("stall", "remainder", held[31:0], last_remainder_out);
        end
        @(posedge CLK);
        next_stall_if_done <= 1'b0;
        wait_edges = 0;
        fell       = 1'b0;
        while (!fell && wait_edges < 10) begin
            @(negedge CLK);
            wait_edges++;
            if (!last_done) fell = 1'b1;
        end
        check_count++;
        assert (fell) else begin
            error_count++;
            $display("stall: last_done stayed high after the stall was released");
        end

        // clear mid-division restarts with new operands
        start_div(32'hFFFF_FFFF, 32'd3, 1'b0, 1'b0);
        repeat (6) begin
            @(negedge CLK);
            check_word("abort", "last_done", 32'd0, {31'd0, last_done});
        end
        run_div("abort", 32'h0000_4321, 32'd17, 1'b0, 1'b0);

        repeat (4) @(posedge CLK);
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- div32_nonrestoring_skip_wrapper.sv
`timescale 1ns/1ps

module div32_nonrestoring_skip_wrapper (
    input  logic                          CLK,
    input  logic                          nRST,
    // control strobes and levels
    input  logic                          next_clear,
    input  logic                          next_is_signed,
    input  logic                          next_stall_if_done,
    output logic                          last_done,
    // operands
    input  logic [div_pkg::DIV_WIDTH-1:0] next_A32_in,
    input  logic [div_pkg::DIV_WIDTH-1:0] next_B32_in,
    // results
    output logic [div_pkg::DIV_WIDTH-1:0] last_quotient_out,
    output logic [div_pkg::DIV_WIDTH-1:0] last_remainder_out
);

    // ------------------------------------------------------------------------
    // core side of the retiming stage

    logic                 clear;
    logic                 stall_if_done;
    div_pkg::div_req_t    req;
    logic                 done;
    div_pkg::div_result_t result;

    div32_nonrestoring_skip i_core (
        .CLK           (CLK),
        .nRST          (nRST),
        .clear         (clear),
        .stall_if_done (stall_if_done),
        .req           (req),
        .done          (done),
        .result        (result)
    );

    // ------------------------------------------------------------------------
    // one flop on every input and output

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            clear              <= 1'b0;
            stall_if_done      <= 1'b0;
            req                <= '0;
            last_done          <= 1'b0;
            last_quotient_out  <= '0;
            last_remainder_out <= '0;
        end else begin
            // inputs toward the core
            clear              <= next_clear;
            stall_if_done      <= next_stall_if_done;
            req.a              <= next_A32_in;
            req.b              <= next_B32_in;
            req.is_signed      <= next_is_signed;
            // outputs from the core
            last_done          <= done;
            last_quotient_out  <= result.quotient;
            last_remainder_out <= result.remainder;
        end
    end

endmodule

//--- div32_nonrestoring_skip.sv
`timescale 1ns/1ps

module div32_nonrestoring_skip (
    input  logic                 CLK,
    input  logic                 nRST,
    input  logic                 clear,
    input  logic                 stall_if_done,
    input  div_pkg::div_req_t    req,
    output logic                 done,
    output div_pkg::div_result_t result
);

    div_pkg::div_state_t           state;
    logic                          last;
    logic                          cnt_load;
    logic                          cnt_step;
    logic [div_pkg::DIV_CNT_W-1:0] skip_steps;

    // counter follows the state, loaded once per division
    assign cnt_load = (state == div_pkg::LOAD);
    assign cnt_step = (state == div_pkg::ITER);

    // ------------------------------------------------------------------------
    // sequencing

    div_fsm i_fsm (
        .CLK           (CLK),
        .nRST          (nRST),
        .clear         (clear),
        .stall_if_done (stall_if_done),
        .last          (last),
        .state         (state),
        .done          (done)
    );

    div_iter_counter i_counter (
        .CLK        (CLK),
        .nRST       (nRST),
        .load       (cnt_load),
        .load_value (skip_steps),
        .step       (cnt_step),
        .last       (last)
    );

    // ------------------------------------------------------------------------
    // datapath

    div_nonrestoring_datapath i_datapath (
        .CLK        (CLK),
        .nRST       (nRST),
        .req        (req),
        .state      (state),
        .skip_steps (skip_steps),
        .result     (result)
    );

endmodule

//--- div_nonrestoring_datapath.sv
`timescale 1ns/1ps

module div_nonrestoring_datapath (
    input  logic                          CLK,
    input  logic                          nRST,
    input  div_pkg::div_req_t             req,
    input  div_pkg::div_state_t           state,
    output logic [div_pkg::DIV_CNT_W-1:0] skip_steps,
    output div_pkg::div_result_t          result
);

    // ------------------------------------------------------------------------
    // operand magnitudes and skip

    logic                          a_neg;
    logic                          b_neg;
    logic [div_pkg::DIV_WIDTH-1:0] a_mag;
    logic [div_pkg::DIV_WIDTH-1:0] b_mag;
    logic [div_pkg::DIV_CNT_W-1:0] lz;

    // sign only counts for signed requests
    assign a_neg = req.is_signed & req.a[div_pkg::DIV_WIDTH-1];
    assign b_neg = req.is_signed & req.b[div_pkg::DIV_WIDTH-1];
    // most negative value maps to 2^31, still fits unsigned
    assign a_mag = a_neg ? (-req.a) : req.a;
    assign b_mag = b_neg ? (-req.b) : req.b;

    div_lead_zero i_lead_zero (
        .value (a_mag),
        .count (lz)
    );

    // zero dividend still runs one step
    assign skip_steps = (lz == div_pkg::DIV_FULL_STEPS) ?
                        {{(div_pkg::DIV_CNT_W-1){1'b0}}, 1'b1} :
                        (div_pkg::DIV_FULL_STEPS - lz);

    // ------------------------------------------------------------------------
    // iteration registers

    // partial remainder, signed, two guard bits
    logic [div_pkg::DIV_REM_W-1:0] p_reg;
    // pre-shifted dividend, quotient bits enter at the bottom
    logic [div_pkg::DIV_WIDTH-1:0] q_reg;
    logic [div_pkg::DIV_WIDTH-1:0] d_reg;
    // original dividend, remainder for divide by zero
    logic [div_pkg::DIV_WIDTH-1:0] a_raw;
    logic                          q_neg;
    logic                          r_neg;
    logic                          div_zero;

    logic [div_pkg::DIV_REM_W-1:0] d_ext;
    logic [div_pkg::DIV_REM_W-1:0] p_shift;
    logic [div_pkg::DIV_REM_W-1:0] p_next;

    assign d_ext   = {{(div_pkg::DIV_REM_W-div_pkg::DIV_WIDTH){1'b0}}, d_reg};
    // shift the next dividend bit into the remainder
    assign p_shift = {p_reg[div_pkg::DIV_REM_W-2:0], q_reg[div_pkg::DIV_WIDTH-1]};
    // negative remainder adds the divisor back, otherwise subtract
    assign p_next  = p_reg[div_pkg::DIV_REM_W-1] ? (p_shift + d_ext) : (p_shift - d_ext);

    always_ff @(posedge CLK) begin
        case (state)
            div_pkg::LOAD: begin
                p_reg <= '0;
                // skip the leading zeros, a shift of 32 leaves zero
                q_reg <= a_mag << lz;
                d_reg <= b_mag;
                a_raw <= req.a;
            end
            div_pkg::ITER: begin
                p_reg <= p_next;
                // quotient bit set when the new remainder is non-negative
                q_reg <= {q_reg[div_pkg::DIV_WIDTH-2:0], ~p_next[div_pkg::DIV_REM_W-1]};
            end
            default: begin
                p_reg <= p_reg;
                q_reg <= q_reg;
            end
        endcase
    end

    // sign and zero flags
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            q_neg    <= 1'b0;
            r_neg    <= 1'b0;
            div_zero <= 1'b0;
        end else if (state == div_pkg::LOAD) begin
            q_neg    <= a_neg ^ b_neg;
            // remainder follows the dividend
            r_neg    <= a_neg;
            div_zero <= (req.b == '0);
        end
    end

    // ------------------------------------------------------------------------
    // fix-up

    logic [div_pkg::DIV_REM_W-1:0] p_fix;
    logic [div_pkg::DIV_WIDTH-1:0] rem_mag;
    div_pkg::div_result_t          result_next;

    // final restore of a negative remainder
    assign p_fix   = p_reg[div_pkg::DIV_REM_W-1] ? (p_reg + d_ext) : p_reg;
    assign rem_mag = p_fix[div_pkg::DIV_WIDTH-1:0];

    always_comb begin
        if (div_zero) begin
            // all-ones quotient, dividend passes through
            result_next.quotient  = '1;
            result_next.remainder = a_raw;
        end else begin
            result_next.quotient  = q_neg ? (-q_reg) : q_reg;
            result_next.remainder = r_neg ? (-rem_mag) : rem_mag;
        end
    end

    // result holds until the next FIX
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            result <= '0;
        end else if (state == div_pkg::FIX) begin
            result <= result_next;
        end
    end

endmodule

//--- div_lead_zero.sv
`timescale 1ns/1ps

module div_lead_zero (
    input  logic [div_pkg::DIV_WIDTH-1:0] value,
    output logic [div_pkg::DIV_CNT_W-1:0] count
);

    // value after each halving stage
    logic [div_pkg::DIV_WIDTH-1:0] v16;
    logic [div_pkg::DIV_WIDTH-1:0] v8;
    logic [div_pkg::DIV_WIDTH-1:0] v4;
    logic [div_pkg::DIV_WIDTH-1:0] v2;

    // one count bit per stage, msb first
    logic [4:0] zbit;

    // ------------------------------------------------------------------------
    // halving search

    // top half empty, skip 16
    assign zbit[4] = (value[31:16] == '0);
    assign v16     = zbit[4] ? (value << 16) : value;

    // skip 8
    assign zbit[3] = (v16[31:24] == '0);
    assign v8      = zbit[3] ? (v16 << 8) : v16;

    // skip 4
    assign zbit[2] = (v8[31:28] == '0);
    assign v4      = zbit[2] ? (v8 << 4) : v8;

    // skip 2
    assign zbit[1] = (v4[31:30] == '0);
    assign v2      = zbit[1] ? (v4 << 2) : v4;

    // last single bit
    assign zbit[0] = ~v2[31];

    // all-zero input reads 31 from the tree, forced to the full width
    assign count = (value == '0) ? div_pkg::DIV_FULL_STEPS : {1'b0, zbit};

endmodule

//--- div_fsm.sv
`timescale 1ns/1ps

module div_fsm (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                clear,
    input  logic                stall_if_done,
    input  logic                last,
    output div_pkg::div_state_t state,
    output logic                done
);

    div_pkg::div_state_t state_next;

    // ------------------------------------------------------------------------
    // state register

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= div_pkg::IDLE;
        end else begin
            state <= state_next;
        end
    end

    // ------------------------------------------------------------------------
    // next state

    always_comb begin
        state_next = state;
        if (clear) begin
            // start or restart from any state
            state_next = div_pkg::LOAD;
        end else begin
            case (state)
                // wait for a clear pulse
                div_pkg::IDLE: state_next = div_pkg::IDLE;
                // operands captured, steps begin next cycle
                div_pkg::LOAD: state_next = div_pkg::ITER;
                // one quotient bit per cycle until the counter runs out
                div_pkg::ITER: begin
                    if (last) begin
                        state_next = div_pkg::FIX;
                    end
                end
                // remainder correction and sign fix-up take one cycle
                div_pkg::FIX:  state_next = div_pkg::DONE;
                // hold the finished state while stalled
                div_pkg::DONE: begin
                    if (!stall_if_done) begin
                        state_next = div_pkg::IDLE;
                    end
                end
                default: state_next = div_pkg::IDLE;
            endcase
        end
    end

    // done is a level for as long as DONE lasts
    assign done = (state == div_pkg::DONE);

endmodule

//--- div_iter_counter.sv
`timescale 1ns/1ps

module div_iter_counter (
    input  logic                       CLK,
    input  logic                       nRST,
    input  logic                       load,
    input  logic [div_pkg::DIV_CNT_W-1:0] load_value,
    input  logic                       step,
    output logic                       last
);

    // remaining non-restoring steps, including the current one
    logic [div_pkg::DIV_CNT_W-1:0] count;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            count <= '0;
        end else if (load) begin
            // number of quotient bits left after the skip
            count <= load_value;
        end else if (step && (count != '0)) begin
            // one bit retired per step
            count <= count - 1'b1;
        end
    end

    // final step is in progress while one remains
    assign last = (count == {{(div_pkg::DIV_CNT_W-1){1'b0}}, 1'b1});

endmodule

//--- div_pkg.sv
package div_pkg;

    // ------------------------------------------------------------------------
    // widths

    // operand and result width
    localparam int DIV_WIDTH = 32;

    // step counter and shift amount, holds 0 to 32
    localparam int DIV_CNT_W = 6;

    // partial remainder, two guard bits over the operand
    // one for the sign, one for the shift before add/sub
    localparam int DIV_REM_W = DIV_WIDTH + 2;

    // step count for a dividend with no leading zeros
    localparam logic [DIV_CNT_W-1:0] DIV_FULL_STEPS = DIV_CNT_W'(DIV_WIDTH);

    // ------------------------------------------------------------------------
    // types

    // core sequencing states
    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        ITER,
        FIX,
        DONE
    } div_state_t;

    // one division request, 65 bits
    typedef struct packed {
        logic [DIV_WIDTH-1:0] a;
        logic [DIV_WIDTH-1:0] b;
        logic                 is_signed;
    } div_req_t;

    // final quotient and remainder, 64 bits
    typedef struct packed {
        logic [DIV_WIDTH-1:0] quotient;
        logic [DIV_WIDTH-1:0] remainder;
    } div_result_t;

endpackage
